//--- bench/byte_repack_tb.sv
`timescale 1ns/100ps

module byte_repack_tb;
  import byte_repack_pkg::*;

  // test lengths in bytes
  localparam int ORDER_BYTES   = 400;
  localparam int MAX_HOLD      = 2 * FIFO_SIZE + 2 * LANES + 2;
  localparam int STALL_BYTES   = 8;
  localparam int PARTIAL_BYTES = 22;
  localparam int TOTAL_BYTES   = ORDER_BYTES + MAX_HOLD + STALL_BYTES + PARTIAL_BYTES + 2;
  localparam int HOLD_CYCLES   = 40;

  logic              clk;
  logic              rst;
  logic [BYTE_W-1:0] in_data;
  logic              in_valid;
  logic              in_ready;
  logic [BYTE_W-1:0] out_data;
  logic              out_valid;
  logic              out_ready;

  logic [7:0]        lfsr_q;
  logic [BYTE_W-1:0] model_q [$];
  logic [BYTE_W-1:0] exp_byte;
  logic [BYTE_W-1:0] hold_data;
  logic              hold_q;
  int                sent_count;
  int                recv_count;
  string             test_name;

  byte_repack_top uut (
    .clk_i       (clk),
    .rst_i       (rst),
    .in_data_i   (in_data),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .out_data_o  (out_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois form, taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    logic [7:0] n;
    n = {1'b0, s[7:1]};
    if (s[0]) begin
      n = n ^ 8'hb8;
    end
    return n;
  endfunction

  function automatic logic rand_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    return b;
  endfunction

  function automatic logic [BYTE_W-1:0] rand_byte();
    logic [BYTE_W-1:0] v;
    for (int i = 0; i < BYTE_W; i++) begin
      v[i] = rand_bit();
    end
    return v;
  endfunction

  // high in quarters out of four
  function automatic logic chance(input int quarters);
    logic [1:0] v;
    v[0] = rand_bit();
    v[1] = rand_bit();
    return int'(v) < quarters;
  endfunction

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    fail_run();
  endtask

  task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                            input logic [BYTE_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  // scoreboard on the rising edge, pre-update values
  always @(posedge clk) begin
    if (!rst) begin
      if (in_valid && in_ready) begin
        model_q.push_back(in_data);
        sent_count++;
      end
      if (out_valid && out_ready) begin
        if (model_q.size() == 0) begin
          stop_on_error("output byte appeared with no byte outstanding");
        end else begin
          exp_byte = model_q.pop_front();
          check_byte(test_name, exp_byte, out_data);
          recv_count++;
        end
      end
      if (hold_q) begin
        check_flag("stable_output_valid", 1'b1, out_valid);
        check_byte("stable_output_data", hold_data, out_data);
      end
      hold_q    = out_valid && !out_ready;
      hold_data = out_data;
    end
  end

  task automatic drive_stream(input int n_bytes, input int valid_q, input int ready_q);
    int                base;
    int                taken;
    logic [BYTE_W-1:0] cur;
    base  = sent_count;
    taken = 0;
    cur   = rand_byte();
    while (taken < n_bytes) begin
      @(negedge clk);
      // last byte went in, draw the next one
      if (sent_count - base != taken) begin
        taken = sent_count - base;
        cur   = rand_byte();
      end
      in_valid  = (taken < n_bytes) ? chance(valid_q) : 1'b0;
      in_data   = cur;
      out_ready = chance(ready_q);
    end
  endtask

  task automatic drain_to(input int left, input int ready_q);
    while (model_q.size() > left) begin
      @(negedge clk);
      out_ready = chance(ready_q);
    end
    out_ready = 1'b0;
  endtask

  task automatic run_back_pressure();
    int                base;
    int                taken;
    logic [BYTE_W-1:0] cur;
    test_name = "back_pressure";
    base      = sent_count;
    taken     = 0;
    cur       = rand_byte();
    out_ready = 1'b0;
    @(negedge clk);
    while (in_ready) begin
      if (sent_count - base != taken) begin
        taken = sent_count - base;
        cur   = rand_byte();
      end
      if (taken > MAX_HOLD) begin
        stop_on_error("more bytes accepted than the design can hold");
      end
      in_valid = 1'b1;
      in_data  = cur;
      @(negedge clk);
    end
    in_valid = 1'b0;
    taken    = sent_count - base;
    if (taken < FIFO_SIZE) begin
      stop_on_error($sformatf("in_ready fell after only %0d bytes", taken));
    end
    drain_to(0, 3);
  endtask

  task automatic run_stall();
    logic [BYTE_W-1:0] first;
    test_name = "stable_output";
    drive_stream(STALL_BYTES, 4, 0);
    out_ready = 1'b0;
    while (!out_valid) begin
      @(negedge clk);
    end
    first = out_data;
    repeat (16) @(negedge clk);
    check_byte("stable_output_hold", first, out_data);
    drain_to(0, 4);
  endtask

  task automatic run_partial();
    int base_recv;
    test_name = "partial_group";
    base_recv = recv_count;
    drive_stream(PARTIAL_BYTES, 3, 2);
    drain_to(2, 3);
    out_ready = 1'b1;
    repeat (HOLD_CYCLES) @(negedge clk);
    check_count("partial_group_out", PARTIAL_BYTES - 2, recv_count - base_recv);
    check_count("partial_group_held", 2, model_q.size());
    // two more bytes complete the held word
    drive_stream(2, 4, 4);
    drain_to(0, 4);
  endtask

  initial begin
    repeat (TOTAL_BYTES * 64 + 1000) @(posedge clk);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial begin
    rst        = 1'b1;
    in_data    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    lfsr_q     = 8'd18;
    hold_q     = 1'b0;
    hold_data  = '0;
    sent_count = 0;
    recv_count = 0;
    test_name  = "reset";
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset_out_valid", 1'b0, out_valid);
    check_flag("reset_in_ready", 1'b1, in_ready);

    test_name = "order";
    drive_stream(ORDER_BYTES, 3, 2);
    drain_to(0, 3);

    run_back_pressure();
    run_stall();
    run_partial();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- byte_repack.f
rtl/byte_repack_pkg.sv
rtl/ram_2p_banked.sv
rtl/ram_asym_wide_write.sv
rtl/ram_asym_narrow_write.sv
rtl/fifo_sync_asym.sv
rtl/fifo_read_stage.sv
rtl/byte_repack_top.sv
bench/byte_repack_tb.sv

//--- rtl/byte_repack_pkg.sv
package byte_repack_pkg;

  // stream and memory widths
  localparam int BYTE_W  = 8;
  localparam int WORD_W  = 32;
  localparam int LANES   = WORD_W / BYTE_W;

  // 64 bytes per FIFO, held as 16 words across 4 byte banks
  localparam int FIFO_ADDR_W = 6;
  localparam int MEM_ADDR_W  = 4;
  localparam int FIFO_SIZE   = 64;

  // level counts bytes and must reach FIFO_SIZE itself
  localparam int LEVEL_W = 7;

  // write request toward the banked RAM
  typedef struct packed {
    logic [LANES-1:0]      en;
    logic [MEM_ADDR_W-1:0] addr;
    logic [WORD_W-1:0]     data;
  } mem_wr_req_t;

  // read request, data returns one cycle later
  typedef struct packed {
    logic [LANES-1:0]      en;
    logic [MEM_ADDR_W-1:0] addr;
  } mem_rd_req_t;

endpackage

//--- rtl/byte_repack_top.sv
`timescale 1ns/100ps

module byte_repack_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // byte stream in
  input  logic [byte_repack_pkg::BYTE_W-1:0]  in_data_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  // byte stream out
  output logic [byte_repack_pkg::BYTE_W-1:0]  out_data_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i
);
  import byte_repack_pkg::*;

  // packing side
  logic              pack_full;
  logic              pack_empty;
  logic              pack_rd_en;
  logic [WORD_W-1:0] pack_rd_data;
  mem_wr_req_t       pack_mem_w;
  mem_rd_req_t       pack_mem_r;
  logic [WORD_W-1:0] pack_mem_rd_data;
  logic [WORD_W-1:0] pack_word;
  logic              pack_word_valid;

  // unpacking side
  logic              unpack_full;
  logic              unpack_empty;
  logic              unpack_rd_en;
  logic [BYTE_W-1:0] unpack_rd_data;
  mem_wr_req_t       unpack_mem_w;
  mem_rd_req_t       unpack_mem_r;
  logic [WORD_W-1:0] unpack_mem_rd_data;

  assign in_ready_o = ~pack_full;

  fifo_sync_asym #(
    .W_DATA_W (BYTE_W),
    .R_DATA_W (WORD_W)
  ) pack_fifo (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .w_en_i           (in_valid_i),
    .w_data_i         (in_data_i),
    .w_full_o         (pack_full),
    .r_en_i           (pack_rd_en),
    .r_data_o         (pack_rd_data),
    .r_empty_o        (pack_empty),
    .ext_mem_w_o      (pack_mem_w),
    .ext_mem_r_o      (pack_mem_r),
    .ext_mem_r_data_i (pack_mem_rd_data),
    .level_o          ()
  );

  ram_2p_banked pack_ram (
    .clk_i    (clk_i),
    .w_req_i  (pack_mem_w),
    .r_req_i  (pack_mem_r),
    .r_data_o (pack_mem_rd_data)
  );

  // words move across only while the unpacking FIFO has room
  fifo_read_stage #(
    .DATA_W (WORD_W)
  ) pack_stage (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .empty_i  (pack_empty),
    .r_en_o   (pack_rd_en),
    .r_data_i (pack_rd_data),
    .data_o   (pack_word),
    .valid_o  (pack_word_valid),
    .ready_i  (~unpack_full)
  );

  fifo_sync_asym #(
    .W_DATA_W (WORD_W),
    .R_DATA_W (BYTE_W)
  ) unpack_fifo (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .w_en_i           (pack_word_valid),
    .w_data_i         (pack_word),
    .w_full_o         (unpack_full),
    .r_en_i           (unpack_rd_en),
    .r_data_o         (unpack_rd_data),
    .r_empty_o        (unpack_empty),
    .ext_mem_w_o      (unpack_mem_w),
    .ext_mem_r_o      (unpack_mem_r),
    .ext_mem_r_data_i (unpack_mem_rd_data),
    .level_o          ()
  );

  ram_2p_banked unpack_ram (
    .clk_i    (clk_i),
    .w_req_i  (unpack_mem_w),
    .r_req_i  (unpack_mem_r),
    .r_data_o (unpack_mem_rd_data)
  );

  fifo_read_stage #(
    .DATA_W (BYTE_W)
  ) unpack_stage (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .empty_i  (unpack_empty),
    .r_en_o   (unpack_rd_en),
    .r_data_i (unpack_rd_data),
    .data_o   (out_data_o),
    .valid_o  (out_valid_o),
    .ready_i  (out_ready_i)
  );

endmodule

//--- rtl/fifo_read_stage.sv
`timescale 1ns/100ps

module fifo_read_stage #(
  parameter int DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // FIFO read side
  input  logic              empty_i,
  output logic              r_en_o,
  input  logic [DATA_W-1:0] r_data_i,
  // stream out
  output logic [DATA_W-1:0] data_o,
  output logic              valid_o,
  input  logic              ready_i
);

  logic              inflight_q;
  logic [1:0]        count_q;
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [DATA_W-1:0] buf_q [2];
  logic              push;
  logic              pop;

  // only read when a slot is sure to be free on return
  assign r_en_o = ~empty_i & (({1'b0, count_q} + {2'b00, inflight_q}) < 3'd2);

  // FIFO data shows up one cycle after the read
  assign push = inflight_q;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= 1'b0;
      count_q    <= '0;
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
    end else begin
      inflight_q <= r_en_o;
      count_q    <= count_q + {1'b0, push} - {1'b0, pop};
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= r_data_i;
    end
  end

  assign valid_o = (count_q != 2'd0);
  assign data_o  = buf_q[rd_ptr_q];

  occupancy_a: assert property (@(posedge clk_i) disable iff (rst_i)
    ({1'b0, count_q} + {2'b00, inflight_q}) <= 3'd2);

  // held output under back-pressure
  hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

//--- rtl/fifo_sync_asym.sv
`timescale 1ns/100ps

module fifo_sync_asym #(
  parameter int W_DATA_W = 8,
  parameter int R_DATA_W = 32
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // write port
  input  logic                                  w_en_i,
  input  logic [W_DATA_W-1:0]                   w_data_i,
  output logic                                  w_full_o,
  // read port
  input  logic                                  r_en_i,
  output logic [R_DATA_W-1:0]                   r_data_o,
  output logic                                  r_empty_o,
  // external memory
  output byte_repack_pkg::mem_wr_req_t          ext_mem_w_o,
  output byte_repack_pkg::mem_rd_req_t          ext_mem_r_o,
  input  logic [byte_repack_pkg::WORD_W-1:0]    ext_mem_r_data_i,
  // fill level in bytes
  output logic [byte_repack_pkg::LEVEL_W-1:0]   level_o
);
  import byte_repack_pkg::*;

  // bytes per access and address width on each side
  localparam int W_INCR   = W_DATA_W / BYTE_W;
  localparam int R_INCR   = R_DATA_W / BYTE_W;
  localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? MEM_ADDR_W : FIFO_ADDR_W;
  localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? MEM_ADDR_W : FIFO_ADDR_W;

  logic                w_acc;
  logic                r_acc;
  logic [W_ADDR_W-1:0] w_addr_q;
  logic [R_ADDR_W-1:0] r_addr_q;
  logic [LEVEL_W-1:0]  level_q;
  logic [LEVEL_W-1:0]  level_nxt;

  // accepted accesses only
  assign w_acc = w_en_i & ~w_full_o;
  assign r_acc = r_en_i & ~r_empty_o;

  always_comb begin
    level_nxt = level_q;
    if (w_acc) begin
      level_nxt = level_nxt + LEVEL_W'(W_INCR);
    end
    if (r_acc) begin
      level_nxt = level_nxt - LEVEL_W'(R_INCR);
    end
  end

  // addresses count in units of their own side and wrap
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_addr_q <= '0;
      r_addr_q <= '0;
    end else begin
      if (w_acc) begin
        w_addr_q <= w_addr_q + 1'b1;
      end
      if (r_acc) begin
        r_addr_q <= r_addr_q + 1'b1;
      end
    end
  end

  // flags come from the next level so they track level_o exactly
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      level_q   <= '0;
      r_empty_o <= 1'b1;
      w_full_o  <= 1'b0;
    end else begin
      level_q   <= level_nxt;
      r_empty_o <= (level_nxt < LEVEL_W'(R_INCR));
      w_full_o  <= (level_nxt > LEVEL_W'(FIFO_SIZE - W_INCR));
    end
  end

  assign level_o = level_q;

  if (W_DATA_W > R_DATA_W) begin : g_wide_write
    ram_asym_wide_write u_adapter (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .w_en_i           (w_acc),
      .w_addr_i         (w_addr_q),
      .w_data_i         (w_data_i),
      .r_en_i           (r_acc),
      .r_addr_i         (r_addr_q),
      .r_data_o         (r_data_o),
      .ext_mem_w_o      (ext_mem_w_o),
      .ext_mem_r_o      (ext_mem_r_o),
      .ext_mem_r_data_i (ext_mem_r_data_i)
    );
  end else begin : g_narrow_write
    ram_asym_narrow_write u_adapter (
      .w_en_i           (w_acc),
      .w_addr_i         (w_addr_q),
      .w_data_i         (w_data_i),
      .r_en_i           (r_acc),
      .r_addr_i         (r_addr_q),
      .r_data_o         (r_data_o),
      .ext_mem_w_o      (ext_mem_w_o),
      .ext_mem_r_o      (ext_mem_r_o),
      .ext_mem_r_data_i (ext_mem_r_data_i)
    );
  end

  level_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
    level_q <= LEVEL_W'(FIFO_SIZE));

  // reader never asks while empty
  read_has_data_a: assert property (@(posedge clk_i) disable iff (rst_i)
    r_en_i |-> !r_empty_o);

endmodule

//--- rtl/ram_2p_banked.sv
`timescale 1ns/100ps

module ram_2p_banked (
  input  logic                                clk_i,
  input  byte_repack_pkg::mem_wr_req_t        w_req_i,
  input  byte_repack_pkg::mem_rd_req_t        r_req_i,
  output logic [byte_repack_pkg::WORD_W-1:0]  r_data_o
);
  import byte_repack_pkg::*;

  // one byte-wide bank per lane
  for (genvar g = 0; g < LANES; g++) begin : g_bank
    logic [BYTE_W-1:0] mem [2**MEM_ADDR_W];
    logic [BYTE_W-1:0] rd_q;

    always_ff @(posedge clk_i) begin
      if (w_req_i.en[g]) begin
        mem[w_req_i.addr] <= w_req_i.data[g*BYTE_W +: BYTE_W];
      end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk_i) begin
      if (r_req_i.en[g]) begin
        rd_q <= mem[r_req_i.addr];
      end
    end

    assign r_data_o[g*BYTE_W +: BYTE_W] = rd_q;
  end

endmodule

//--- rtl/ram_asym_narrow_write.sv
`timescale 1ns/100ps

module ram_asym_narrow_write (
  // byte write
  input  logic                                      w_en_i,
  input  logic [byte_repack_pkg::FIFO_ADDR_W-1:0]   w_addr_i,
  input  logic [byte_repack_pkg::BYTE_W-1:0]        w_data_i,
  // word read
  input  logic                                      r_en_i,
  input  logic [byte_repack_pkg::MEM_ADDR_W-1:0]    r_addr_i,
  output logic [byte_repack_pkg::WORD_W-1:0]        r_data_o,
  // banked RAM side
  output byte_repack_pkg::mem_wr_req_t              ext_mem_w_o,
  output byte_repack_pkg::mem_rd_req_t              ext_mem_r_o,
  input  logic [byte_repack_pkg::WORD_W-1:0]        ext_mem_r_data_i
);
  import byte_repack_pkg::*;

  logic [FIFO_ADDR_W-MEM_ADDR_W-1:0] w_lane;

  // byte k lands in bank k mod 4, word k/4
  assign w_lane = w_addr_i[FIFO_ADDR_W-MEM_ADDR_W-1:0];

  always_comb begin
    ext_mem_w_o.en = '0;
    if (w_en_i) begin
      ext_mem_w_o.en = LANES'(1) << w_lane;
    end
    ext_mem_w_o.addr = w_addr_i[FIFO_ADDR_W-1:FIFO_ADDR_W-MEM_ADDR_W];
    // every lane sees the byte, only the enabled bank takes it
    ext_mem_w_o.data = {LANES{w_data_i}};
  end

  always_comb begin
    ext_mem_r_o.en   = {LANES{r_en_i}};
    ext_mem_r_o.addr = r_addr_i;
  end

  // whole word, already little-endian across the banks
  assign r_data_o = ext_mem_r_data_i;

endmodule

//--- rtl/ram_asym_wide_write.sv
`timescale 1ns/100ps

module ram_asym_wide_write (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // word write
  input  logic                                      w_en_i,
  input  logic [byte_repack_pkg::MEM_ADDR_W-1:0]    w_addr_i,
  input  logic [byte_repack_pkg::WORD_W-1:0]        w_data_i,
  // byte read
  input  logic                                      r_en_i,
  input  logic [byte_repack_pkg::FIFO_ADDR_W-1:0]   r_addr_i,
  output logic [byte_repack_pkg::BYTE_W-1:0]        r_data_o,
  // banked RAM side
  output byte_repack_pkg::mem_wr_req_t              ext_mem_w_o,
  output byte_repack_pkg::mem_rd_req_t              ext_mem_r_o,
  input  logic [byte_repack_pkg::WORD_W-1:0]        ext_mem_r_data_i
);
  import byte_repack_pkg::*;

  // lane of the byte being read, lined up with the RAM latency
  logic [FIFO_ADDR_W-MEM_ADDR_W-1:0] lane_q;

  // a word fills every bank at one address
  always_comb begin
    ext_mem_w_o.en   = {LANES{w_en_i}};
    ext_mem_w_o.addr = w_addr_i;
    ext_mem_w_o.data = w_data_i;
  end

  always_comb begin
    ext_mem_r_o.en   = {LANES{r_en_i}};
    ext_mem_r_o.addr = r_addr_i[FIFO_ADDR_W-1:FIFO_ADDR_W-MEM_ADDR_W];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_q <= '0;
    end else if (r_en_i) begin
      lane_q <= r_addr_i[FIFO_ADDR_W-MEM_ADDR_W-1:0];
    end
  end

  // bank 0 is the low byte
  assign r_data_o = ext_mem_r_data_i[lane_q*BYTE_W +: BYTE_W];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the byte_repack testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f byte_repack.f \
  --top-module byte_repack_tb -o byte_repack_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/byte_repack_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
